//--- common/stq_cfg_pkg.sv
package stq_cfg_pkg;

  // even/odd line address as seen by the load/store pipes
  parameter int ADDR_W = 36;

  // byte enables within one bank word
  parameter int BYTES_W = 4;

  // one bit per sub-bank the access touches
  parameter int SUBBNK_W = 8;

  // store data width
  parameter int DATA_W = 32;

  // default entry count, power of two between 2 and 16
  parameter int DEPTH_DEF = 8;

  // load search ports checked every cycle
  parameter int NUM_CHK = 2;

endpackage

//--- common/stq_types_pkg.sv
package stq_types_pkg;

  // drain sequencing toward the data cache
  typedef enum logic [1:0] {
    DR_IDLE = 2'd0, // head not committed yet
    DR_SEND = 2'd1, // strobe goes out now if cache is ready
    DR_WAIT = 2'd2  // held off by cache_ready
  } drain_state_e;

  // outcome of one load search
  typedef enum logic [1:0] {
    FWD_NONE    = 2'd0,
    FWD_FULL    = 2'd1,
    FWD_PARTIAL = 2'd2
  } fwd_kind_e;

endpackage

//--- project.f
common/stq_cfg_pkg.sv
common/stq_types_pkg.sv
stq/stq_entry.sv
stq/stq_ctrl.sv
stq/stq_fwd_sel.sv
source/stq_top.sv
sim/stq_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the store queue testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module stq_tb -f project.f -o stq_sim || exit 1
./obj_dir/stq_sim > sim.log 2>&1
grep -q "Simulation FAILED" sim.log && { echo "run failed, see sim.log"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "no result in sim.log"; exit 1; }
echo "run passed"

//--- sim/stq_tb.sv
module stq_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import stq_cfg_pkg::*;

  localparam int DEPTH = DEPTH_DEF;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int RAND_CYC = 400;
  localparam int TOTAL_CYC = RAND_CYC + 200;

  logic clk, rst, alloc_en, alloc_odd, upd_en, retire_en, cache_ready;
  logic full, drain_en, drain_odd;
  logic [ADDR_W-1:0] alloc_addr, drain_addr;
  logic [BYTES_W-1:0] alloc_bytes, drain_bytes;
  logic [SUBBNK_W-1:0] alloc_subbnk, drain_subbnk;
  logic [PTR_W-1:0] upd_idx, alloc_idx;
  logic [DATA_W-1:0] upd_data, drain_data;
  logic [NUM_CHK-1:0] chk_en, chk_odd, fwd_match, fwd_partial;
  logic [NUM_CHK-1:0][ADDR_W-1:0] chk_addr;
  logic [NUM_CHK-1:0][BYTES_W-1:0] chk_bytes;
  logic [NUM_CHK-1:0][SUBBNK_W-1:0] chk_subbnk;
  logic [NUM_CHK-1:0][DATA_W-1:0] fwd_data;
  integer seed = 5;
  int drain_cnt;

  // reference copy of the queue
  logic [ADDR_W-1:0] m_addr [DEPTH];
  logic [BYTES_W-1:0] m_bytes [DEPTH];
  logic [SUBBNK_W-1:0] m_sub [DEPTH];
  logic [DATA_W-1:0] m_data [DEPTH];
  logic [DEPTH-1:0] m_odd, m_free, m_upd, m_passe;
  logic [PTR_W-1:0] m_head, m_cmt, m_tail;
  int m_cnt, m_pend; // live count and uncommitted live count
  logic dr_busy; // committed head waiting for the cache
  logic exp_full, exp_drain;
  logic [NUM_CHK-1:0] exp_match, exp_partial;
  logic [NUM_CHK-1:0][DATA_W-1:0] exp_data;

  stq_top #(.DEPTH(DEPTH)) DUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #(TOTAL_CYC * 8 * 2);
    stop_run("timeout, the test sequence never reached its end");
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic flag_mismatch(input string sig, input logic [63:0] expv,
                               input logic [63:0] gotv);
    stop_run($sformatf("mismatch at %0t: %s expected %0h got %0h", $time, sig, expv, gotv));
  endtask

  assign exp_full = (m_cnt == DEPTH);
  assign exp_drain = dr_busy && cache_ready;

  always @(posedge clk) begin
    logic [PTR_W-1:0] k;
    logic hit, alloc_ok, retire_ok;
    alloc_ok = alloc_en && (m_cnt < DEPTH);
    retire_ok = retire_en && (m_pend != 0);
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        m_addr[i] <= '0;
        m_bytes[i] <= '0;
        m_sub[i] <= '0;
        m_data[i] <= '0;
      end
      m_odd <= '0;
      m_free <= '1;
      m_upd <= '1;
      m_passe <= '0;
      m_head <= '0;
      m_cmt <= '0;
      m_tail <= '0;
      m_cnt <= 0;
      m_pend <= 0;
      dr_busy <= 1'b0;
      exp_match <= '0;
      exp_partial <= '0;
      exp_data <= '0;
    end else begin
      // youngest live store first from pre-edge state
      for (int p = 0; p < NUM_CHK; p++) begin
        hit = 1'b0;
        exp_match[p] <= 1'b0;
        exp_partial[p] <= 1'b0;
        exp_data[p] <= '0;
        for (int n = 1; n <= DEPTH; n++) begin
          k = m_tail - PTR_W'(n);
          if (!hit && chk_en[p] && !m_free[k] && !m_passe[k] && chk_addr[p] == m_addr[k] &&
              chk_odd[p] == m_odd[k] && (chk_subbnk[p] & m_sub[k]) != '0) begin
            hit = 1'b1;
            if (m_upd[k] && (chk_bytes[p] & ~m_bytes[k]) == '0) begin
              exp_match[p] <= 1'b1;
              exp_data[p] <= m_data[k];
            end else begin
              exp_partial[p] <= 1'b1;
            end
          end
        end
      end
      if (upd_en && !m_free[upd_idx] && !m_passe[upd_idx]) begin
        m_upd[upd_idx] <= 1'b1;
        m_data[upd_idx] <= upd_data;
      end
      if (alloc_ok) begin
        m_addr[m_tail] <= alloc_addr;
        m_odd[m_tail] <= alloc_odd;
        m_bytes[m_tail] <= alloc_bytes;
        m_sub[m_tail] <= alloc_subbnk;
        m_free[m_tail] <= 1'b0;
        m_upd[m_tail] <= 1'b0;
        m_passe[m_tail] <= 1'b0;
        m_tail <= m_tail + 1'b1;
      end
      if (retire_ok) begin
        m_passe[m_cmt] <= 1'b1;
        m_cmt <= m_cmt + 1'b1;
      end
      if (exp_drain) begin
        m_free[m_head] <= 1'b1;
        m_passe[m_head] <= 1'b0;
        m_head <= m_head + 1'b1;
        dr_busy <= 1'b0;
      end else if (!dr_busy) begin
        dr_busy <= m_passe[m_head] && !m_free[m_head];
      end
      m_cnt <= m_cnt + (alloc_ok ? 1 : 0) - (exp_drain ? 1 : 0);
      m_pend <= m_pend + (alloc_ok ? 1 : 0) - (retire_ok ? 1 : 0);
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      drain_cnt <= 0;
    end else if (drain_en) begin
      drain_cnt <= drain_cnt + 1;
    end
  end

  a_full: assert property (@(posedge clk) disable iff (rst) full == exp_full)
    else flag_mismatch("full", 64'($sampled(exp_full)), 64'($sampled(full)));
  a_idx: assert property (@(posedge clk) disable iff (rst) alloc_idx == m_tail)
    else flag_mismatch("alloc_idx", 64'($sampled(m_tail)), 64'($sampled(alloc_idx)));
  a_drain: assert property (@(posedge clk) disable iff (rst) drain_en == exp_drain)
    else flag_mismatch("drain_en", 64'($sampled(exp_drain)), 64'($sampled(drain_en)));
  a_dfields: assert property (@(posedge clk) disable iff (rst) drain_en |->
      {drain_addr, drain_odd, drain_bytes, drain_subbnk} ==
      {m_addr[m_head], m_odd[m_head], m_bytes[m_head], m_sub[m_head]})
    else flag_mismatch("drain_addr/odd/bytes/subbnk",
      64'($sampled({m_addr[m_head], m_odd[m_head], m_bytes[m_head], m_sub[m_head]})),
      64'($sampled({drain_addr, drain_odd, drain_bytes, drain_subbnk})));
  a_ddata: assert property (@(posedge clk) disable iff (rst)
      drain_en |-> drain_data == m_data[m_head])
    else flag_mismatch("drain_data", 64'($sampled(m_data[m_head])), 64'($sampled(drain_data)));
  a_match: assert property (@(posedge clk) disable iff (rst) fwd_match == exp_match)
    else flag_mismatch("fwd_match", 64'($sampled(exp_match)), 64'($sampled(fwd_match)));
  a_part: assert property (@(posedge clk) disable iff (rst) fwd_partial == exp_partial)
    else flag_mismatch("fwd_partial", 64'($sampled(exp_partial)), 64'($sampled(fwd_partial)));
  a_data: assert property (@(posedge clk) disable iff (rst) fwd_data == exp_data)
    else flag_mismatch("fwd_data", 64'($sampled(exp_data)), 64'($sampled(fwd_data)));

  // strobes last one cycle
  task automatic tick();
    @(negedge clk);
    alloc_en = 1'b0;
    upd_en = 1'b0;
    retire_en = 1'b0;
    chk_en = '0;
  endtask

  task automatic alloc_store(input logic [ADDR_W-1:0] a, input logic o,
                             input logic [BYTES_W-1:0] b, input logic [SUBBNK_W-1:0] s);
    alloc_en = 1'b1;
    alloc_addr = a;
    alloc_odd = o;
    alloc_bytes = b;
    alloc_subbnk = s;
    tick();
  endtask

  task automatic update(input logic [PTR_W-1:0] idx, input logic [DATA_W-1:0] d);
    upd_en = 1'b1;
    upd_idx = idx;
    upd_data = d;
    tick();
  endtask

  task automatic search(input int p, input logic [ADDR_W-1:0] a, input logic o,
                        input logic [BYTES_W-1:0] b, input logic [SUBBNK_W-1:0] s);
    chk_en[p] = 1'b1;
    chk_addr[p] = a;
    chk_odd[p] = o;
    chk_bytes[p] = b;
    chk_subbnk[p] = s;
  endtask

  task automatic retire_n(input int n);
    repeat (n) begin
      retire_en = 1'b1;
      tick();
    end
  endtask

  task automatic drain_until(input int target);
    int cyc;
    cyc = 0;
    cache_ready = 1'b1;
    while (drain_cnt < target) begin
      if (cyc == 4 * DEPTH) stop_run("drain_en never freed all committed stores");
      tick();
      cyc++;
    end
  endtask

  initial begin
    logic [PTR_W-1:0] i0, i1;
    int target;
    rst = 1'b1;
    {alloc_en, alloc_odd, upd_en, retire_en, cache_ready} = '0;
    alloc_addr = '0;
    alloc_bytes = '0;
    alloc_subbnk = '0;
    upd_idx = '0;
    upd_data = '0;
    {chk_en, chk_odd, chk_addr, chk_bytes, chk_subbnk} = '0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    search(0, ADDR_W'($random(seed)), 1'b0, '1, '1);
    search(1, ADDR_W'($random(seed)), 1'b1, '1, '1);
    tick();
    // fill to full then try one more that must be dropped
    for (int i = 0; i < DEPTH; i++) alloc_store(ADDR_W'(i + 16), 1'b0, '1, '1);
    for (int i = 0; i < DEPTH; i++) update(PTR_W'(i), DATA_W'($random(seed)));
    alloc_store(36'h5, 1'b1, '1, '1);
    search(0, ADDR_W'(DEPTH + 15), 1'b0, 4'b0110, 8'h10);
    tick();
    retire_n(DEPTH);
    search(0, ADDR_W'(DEPTH + 15), 1'b0, 4'b0110, 8'h10); // committed so no hit
    repeat (4) tick();
    drain_until(DEPTH);
    i0 = alloc_idx;
    alloc_store(36'h123, 1'b0, 4'b1111, 8'h0f);
    search(0, 36'h123, 1'b0, 4'b0011, 8'h01); // data still missing
    tick();
    update(i0, 32'hcafe_0001);
    search(0, 36'h123, 1'b0, 4'b0011, 8'h01);
    search(1, 36'h123, 1'b0, 4'b1100, 8'h08);
    tick();
    i1 = alloc_idx;
    alloc_store(36'h123, 1'b0, 4'b0001, 8'h02);
    update(i1, 32'hbeef_0002);
    search(0, 36'h123, 1'b0, 4'b0011, 8'h03); // younger store wins with a partial
    search(1, 36'h123, 1'b0, 4'b0001, 8'h02);
    tick();
    search(0, 36'h123, 1'b1, 4'b0001, 8'h02);
    search(1, 36'h123, 1'b0, 4'b0001, 8'hf0);
    tick();
    retire_n(2);
    drain_until(DEPTH + 2);
    for (int c = 0; c < RAND_CYC; c++) begin
      alloc_en = ($random(seed) & 1) == 1;
      alloc_addr = ADDR_W'($random(seed) & 3); // few lines for many overlaps
      alloc_odd = 1'($random(seed));
      alloc_bytes = BYTES_W'($random(seed));
      alloc_subbnk = SUBBNK_W'($random(seed));
      upd_en = ($random(seed) & 1) == 1;
      upd_idx = PTR_W'($random(seed));
      upd_data = DATA_W'($random(seed));
      retire_en = ($random(seed) & 1) == 1;
      cache_ready = ($random(seed) & 3) != 0;
      for (int p = 0; p < NUM_CHK; p++) begin
        search(p, ADDR_W'($random(seed) & 3), 1'($random(seed)),
               BYTES_W'($random(seed)), SUBBNK_W'($random(seed)));
        chk_en[p] = 1'($random(seed));
      end
      tick();
    end
    target = drain_cnt + m_cnt;
    retire_n(DEPTH);
    drain_until(target);
    repeat (3) tick();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- source/stq_top.sv
module stq_top #(
  parameter int DEPTH = stq_cfg_pkg::DEPTH_DEF
) (
  input  logic clk,
  input  logic rst,
  input  logic alloc_en,
  input  logic [stq_cfg_pkg::ADDR_W-1:0] alloc_addr,
  input  logic alloc_odd,
  input  logic [stq_cfg_pkg::BYTES_W-1:0] alloc_bytes,
  input  logic [stq_cfg_pkg::SUBBNK_W-1:0] alloc_subbnk,
  input  logic upd_en,
  input  logic [$clog2(DEPTH)-1:0] upd_idx,
  input  logic [stq_cfg_pkg::DATA_W-1:0] upd_data,
  input  logic retire_en,
  input  logic cache_ready,
  input  logic [stq_cfg_pkg::NUM_CHK-1:0] chk_en,
  input  logic [stq_cfg_pkg::NUM_CHK-1:0][stq_cfg_pkg::ADDR_W-1:0] chk_addr,
  input  logic [stq_cfg_pkg::NUM_CHK-1:0] chk_odd,
  input  logic [stq_cfg_pkg::NUM_CHK-1:0][stq_cfg_pkg::BYTES_W-1:0] chk_bytes,
  input  logic [stq_cfg_pkg::NUM_CHK-1:0][stq_cfg_pkg::SUBBNK_W-1:0] chk_subbnk,
  output logic [$clog2(DEPTH)-1:0] alloc_idx,
  output logic full,
  output logic drain_en,
  output logic [stq_cfg_pkg::ADDR_W-1:0] drain_addr,
  output logic drain_odd,
  output logic [stq_cfg_pkg::BYTES_W-1:0] drain_bytes,
  output logic [stq_cfg_pkg::SUBBNK_W-1:0] drain_subbnk,
  output logic [stq_cfg_pkg::DATA_W-1:0] drain_data,
  output logic [stq_cfg_pkg::NUM_CHK-1:0] fwd_match,
  output logic [stq_cfg_pkg::NUM_CHK-1:0] fwd_partial,
  output logic [stq_cfg_pkg::NUM_CHK-1:0][stq_cfg_pkg::DATA_W-1:0] fwd_data
);
  import stq_cfg_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  logic [DEPTH-1:0] wrt;
  logic [DEPTH-1:0] passe_set;
  logic [DEPTH-1:0] free_set;
  logic [DEPTH-1:0] upd_sel;
  logic [DEPTH-1:0] entry_free;
  logic [DEPTH-1:0] entry_passe;
  logic [DEPTH-1:0][NUM_CHK-1:0] overlap;
  logic [DEPTH-1:0][NUM_CHK-1:0] covers;
  logic [DEPTH-1:0][ADDR_W-1:0] e_addr;
  logic [DEPTH-1:0] e_odd;
  logic [DEPTH-1:0][BYTES_W-1:0] e_bytes;
  logic [DEPTH-1:0][SUBBNK_W-1:0] e_subbnk;
  logic [DEPTH-1:0][DATA_W-1:0] e_data;
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;

  stq_ctrl #(.DEPTH(DEPTH)) u_ctrl (
    .clk(clk), .rst(rst),
    .alloc_en(alloc_en), .retire_en(retire_en), .cache_ready(cache_ready),
    .entry_free(entry_free), .entry_passe(entry_passe),
    .wrt(wrt), .passe_set(passe_set), .free_set(free_set),
    .alloc_idx(alloc_idx), .tail(tail), .head(head),
    .full(full), .drain_en(drain_en)
  );

  for (genvar i = 0; i < DEPTH; i++) begin : g_entry
    assign upd_sel[i] = upd_en && (upd_idx == PTR_W'(i));

    stq_entry u_entry (
      .clk(clk), .rst(rst), .wrt(wrt[i]),
      .alloc_addr(alloc_addr), .alloc_odd(alloc_odd),
      .alloc_bytes(alloc_bytes), .alloc_subbnk(alloc_subbnk),
      .upd_en(upd_sel[i]), .upd_data(upd_data),
      .passe_en(passe_set[i]), .free_en(free_set[i]),
      .chk_en(chk_en), .chk_addr(chk_addr), .chk_odd(chk_odd),
      .chk_bytes(chk_bytes), .chk_subbnk(chk_subbnk),
      .overlap(overlap[i]), .covers(covers[i]),
      .free(entry_free[i]), .passe(entry_passe[i]),
      .addr(e_addr[i]), .odd(e_odd[i]), .bytes(e_bytes[i]),
      .subbnk(e_subbnk[i]), .data(e_data[i])
    );
  end

  stq_fwd_sel #(.DEPTH(DEPTH)) u_fwd_sel (
    .clk(clk), .rst(rst),
    .overlap(overlap), .covers(covers), .entry_data(e_data), .tail(tail),
    .fwd_match(fwd_match), .fwd_partial(fwd_partial), .fwd_data(fwd_data)
  );

  // head entry goes out, valid while drain_en
  assign drain_addr = e_addr[head];
  assign drain_odd = e_odd[head];
  assign drain_bytes = e_bytes[head];
  assign drain_subbnk = e_subbnk[head];
  assign drain_data = e_data[head];

endmodule

//--- stq/stq_ctrl.sv
module stq_ctrl #(
  parameter int DEPTH = stq_cfg_pkg::DEPTH_DEF
) (
  input  logic clk,
  input  logic rst,
  input  logic alloc_en,
  input  logic retire_en,
  input  logic cache_ready,
  input  logic [DEPTH-1:0] entry_free,
  input  logic [DEPTH-1:0] entry_passe,
  output logic [DEPTH-1:0] wrt,
  output logic [DEPTH-1:0] passe_set,
  output logic [DEPTH-1:0] free_set,
  output logic [$clog2(DEPTH)-1:0] alloc_idx,
  output logic [$clog2(DEPTH)-1:0] tail,
  output logic [$clog2(DEPTH)-1:0] head,
  output logic full,
  output logic drain_en
);
  import stq_types_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  // msb is the wrap bit
  logic [PTR_W:0] head_q;
  logic [PTR_W:0] cmt_q;
  logic [PTR_W:0] tail_q;
  logic alloc_ok;
  logic retire_ok;
  logic head_ready;
  drain_state_e state;
  drain_state_e state_nxt;

  assign head = head_q[PTR_W-1:0];
  assign tail = tail_q[PTR_W-1:0];
  assign alloc_idx = tail;

  assign full = (head_q[PTR_W] != tail_q[PTR_W]) && (head == tail);
  assign alloc_ok = alloc_en && !full;
  assign retire_ok = retire_en && (cmt_q != tail_q); // something left to commit

  assign head_ready = entry_passe[head] && !entry_free[head];
  assign drain_en = ((state == DR_SEND) || (state == DR_WAIT)) && cache_ready;

  always_comb begin
    wrt = '0;
    passe_set = '0;
    free_set = '0;
    wrt[tail] = alloc_ok;
    passe_set[cmt_q[PTR_W-1:0]] = retire_ok;
    free_set[head] = drain_en;
  end

  always_comb begin
    state_nxt = state;
    case (state)
      DR_IDLE: begin
        if (head_ready) begin
          state_nxt = DR_SEND;
        end
      end
      DR_SEND: begin
        state_nxt = cache_ready ? DR_IDLE : DR_WAIT;
      end
      DR_WAIT: begin
        if (cache_ready) begin
          state_nxt = DR_IDLE;
        end
      end
      default: state_nxt = DR_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= DR_IDLE;
      head_q <= '0;
      cmt_q <= '0;
      tail_q <= '0;
    end else begin
      state <= state_nxt;
      if (alloc_ok) begin
        tail_q <= tail_q + 1'b1;
      end
      if (retire_ok) begin
        cmt_q <= cmt_q + 1'b1;
      end
      if (drain_en) begin
        head_q <= head_q + 1'b1; // entry freed on the same edge
      end
    end
  end

endmodule

//--- stq/stq_entry.sv
module stq_entry (
  input  logic clk,
  input  logic rst,
  input  logic wrt,
  input  logic [stq_cfg_pkg::ADDR_W-1:0] alloc_addr,
  input  logic alloc_odd,
  input  logic [stq_cfg_pkg::BYTES_W-1:0] alloc_bytes,
  input  logic [stq_cfg_pkg::SUBBNK_W-1:0] alloc_subbnk,
  input  logic upd_en,
  input  logic [stq_cfg_pkg::DATA_W-1:0] upd_data,
  input  logic passe_en,
  input  logic free_en,
  input  logic [stq_cfg_pkg::NUM_CHK-1:0] chk_en,
  input  logic [stq_cfg_pkg::NUM_CHK-1:0][stq_cfg_pkg::ADDR_W-1:0] chk_addr,
  input  logic [stq_cfg_pkg::NUM_CHK-1:0] chk_odd,
  input  logic [stq_cfg_pkg::NUM_CHK-1:0][stq_cfg_pkg::BYTES_W-1:0] chk_bytes,
  input  logic [stq_cfg_pkg::NUM_CHK-1:0][stq_cfg_pkg::SUBBNK_W-1:0] chk_subbnk,
  output logic [stq_cfg_pkg::NUM_CHK-1:0] overlap,
  output logic [stq_cfg_pkg::NUM_CHK-1:0] covers,
  output logic free,
  output logic passe,
  output logic [stq_cfg_pkg::ADDR_W-1:0] addr,
  output logic odd,
  output logic [stq_cfg_pkg::BYTES_W-1:0] bytes,
  output logic [stq_cfg_pkg::SUBBNK_W-1:0] subbnk,
  output logic [stq_cfg_pkg::DATA_W-1:0] data
);
  import stq_cfg_pkg::*;

  logic upd; // store data present
  logic upd_ok;

  // data only lands on a live, uncommitted store
  assign upd_ok = upd_en && !free && !passe;

  always_comb begin
    for (int p = 0; p < NUM_CHK; p++) begin
      overlap[p] = chk_en[p] && !free && !passe && (chk_addr[p] == addr) &&
                   (chk_odd[p] == odd) && |(chk_subbnk[p] & subbnk);
      // no load byte outside the store bytes
      covers[p] = upd && ((chk_bytes[p] & ~bytes) == '0);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      addr <= '0;
      odd <= 1'b0;
      bytes <= '0;
      subbnk <= '0;
      data <= '0;
      free <= 1'b1;
      upd <= 1'b1;
      passe <= 1'b0;
    end else begin
      if (free_en) begin
        free <= 1'b1;
        passe <= 1'b0;
      end else if (passe_en) begin
        passe <= 1'b1;
      end else if (wrt) begin
        addr <= alloc_addr;
        odd <= alloc_odd;
        bytes <= alloc_bytes;
        subbnk <= alloc_subbnk;
        free <= 1'b0;
        passe <= 1'b0;
        upd <= 1'b0; // data follows later by index
      end
      if (upd_ok) begin
        upd <= 1'b1;
        data <= upd_data;
      end
    end
  end

endmodule

//--- stq/stq_fwd_sel.sv
module stq_fwd_sel #(
  parameter int DEPTH = stq_cfg_pkg::DEPTH_DEF
) (
  input  logic clk,
  input  logic rst,
  input  logic [DEPTH-1:0][stq_cfg_pkg::NUM_CHK-1:0] overlap,
  input  logic [DEPTH-1:0][stq_cfg_pkg::NUM_CHK-1:0] covers,
  input  logic [DEPTH-1:0][stq_cfg_pkg::DATA_W-1:0] entry_data,
  input  logic [$clog2(DEPTH)-1:0] tail,
  output logic [stq_cfg_pkg::NUM_CHK-1:0] fwd_match,
  output logic [stq_cfg_pkg::NUM_CHK-1:0] fwd_partial,
  output logic [stq_cfg_pkg::NUM_CHK-1:0][stq_cfg_pkg::DATA_W-1:0] fwd_data
);
  import stq_cfg_pkg::*;
  import stq_types_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  // rotated so that bit 0 is the entry just below tail
  logic [NUM_CHK-1:0][DEPTH-1:0] ov_rot;
  logic [NUM_CHK-1:0][PTR_W-1:0] sel_idx;
  fwd_kind_e kind [NUM_CHK];

  always_comb begin
    for (int p = 0; p < NUM_CHK; p++) begin
      for (int i = 0; i < DEPTH; i++) begin
        ov_rot[p][i] = overlap[tail - PTR_W'(i + 1)][p];
      end
    end
  end

  always_comb begin
    for (int p = 0; p < NUM_CHK; p++) begin
      sel_idx[p] = '0;
      kind[p] = FWD_NONE;
      // oldest first, lowest hit is kept last
      for (int i = DEPTH - 1; i >= 0; i--) begin
        if (ov_rot[p][i]) begin
          sel_idx[p] = tail - PTR_W'(i + 1);
        end
      end
      if (|ov_rot[p]) begin
        kind[p] = covers[sel_idx[p]][p] ? FWD_FULL : FWD_PARTIAL;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fwd_match <= '0;
      fwd_partial <= '0;
      fwd_data <= '0;
    end else begin
      for (int p = 0; p < NUM_CHK; p++) begin
        fwd_match[p] <= (kind[p] == FWD_FULL);
        fwd_partial[p] <= (kind[p] == FWD_PARTIAL); // load replays
        fwd_data[p] <= (kind[p] == FWD_FULL) ? entry_data[sel_idx[p]] : '0;
      end
    end
  end

endmodule
